/* hw/rv_isa_pkg.sv */
`default_nettype none

// rv32i encodings needed by the fetch front end
package rv_isa_pkg;

    // instruction word width
    parameter int unsigned INST_W = 32;

    // byte address width
    parameter int unsigned ADDR_W = 32;

    // major opcode field, bits [6:0] of every word
    parameter int unsigned OPCODE_W = 7;

    // major opcodes seen by the predecoder
    typedef enum logic [OPCODE_W-1:0] {
        // register-immediate alu ops, addi and friends
        op_imm = 7'b0010011,
        // register-register alu ops
        op     = 7'b0110011,
        // loads
        load   = 7'b0000011,
        // stores
        store  = 7'b0100011,
        // conditional branches, b-type immediate
        branch = 7'b1100011,
        // jump and link, j-type immediate
        jal    = 7'b1101111,
        // indirect jump, target needs rs1
        jalr   = 7'b1100111,
        // upper immediate
        lui    = 7'b0110111,
        // pc-relative upper immediate
        auipc  = 7'b0010111
    } rv_opcode_t;

    // addi x0, x0, 0
    // canonical nop, used to fill slots that carry no instruction
    parameter logic [INST_W-1:0] NOP_INST = {
        12'h000,
        5'd0,
        3'b000,
        5'd0,
        7'b0010011
    };

endpackage

`default_nettype wire

/* hw/fetch_pkg.sv */
`default_nettype none

// constants and types shared by the fetch modules
package fetch_pkg;

    // control-transfer class from predecode
    typedef enum logic [1:0] {
        // not a control transfer
        ctl_none   = 2'b00,
        // conditional branch, b-type
        ctl_branch = 2'b01,
        // direct jump, j-type
        ctl_jal    = 2'b10,
        // indirect jump, not predicted
        ctl_jalr   = 2'b11
    } ctl_class_t;

    // bytes per instruction slot
    // pc step from slot 0 to slot 1
    parameter int unsigned INST_BYTES = 4;

    // bytes per fetch packet
    // two slots, pc step for a packet with no predicted transfer
    parameter int unsigned PACKET_BYTES = 2 * INST_BYTES;

endpackage

`default_nettype wire

/* hw/program_memory.sv */
`timescale 1ns/1ps
`default_nettype none

// word-organized program memory
// byte addressed, one synchronous write port, two combinational read ports
module program_memory #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic                           clk,
    input  logic [rv_isa_pkg::ADDR_W-1:0]  byte_address,
    input  logic                           write_enable,
    input  logic [rv_isa_pkg::INST_W-1:0]  write_data,
    output logic [rv_isa_pkg::INST_W-1:0]  curr_read_data,
    output logic [rv_isa_pkg::INST_W-1:0]  next_read_data
);

    import rv_isa_pkg::*;

    // bits needed to index one word
    localparam int unsigned WORD_AW = $clog2(MEM_WORDS);

    // storage, no reset, filled through the write port
    logic [INST_W-1:0] mem [0:MEM_WORDS-1];

    // index of the addressed word and of the one after it
    logic [WORD_AW-1:0] curr_index;
    logic [WORD_AW-1:0] next_index;

    // drop the byte offset, truncate to the memory depth
    assign curr_index = byte_address[WORD_AW+1:2];

    // following word, wraps back to word 0 at the top
    assign next_index = (curr_index == WORD_AW'(MEM_WORDS - 1)) ? '0 :
                        curr_index + 1'b1;

    // write lands at the edge
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[curr_index] <= write_data;
        end
    end

    // both reads are combinational
    // a same-cycle write to the word is not yet visible
    assign curr_read_data = mem[curr_index];
    assign next_read_data = mem[next_index];

    // program words only go to aligned addresses
    // a misaligned write would silently land on the truncated word
    write_aligned_check: assert property (
        @(posedge clk) write_enable |-> (byte_address[1:0] == 2'b00)
    ) else $error("program_memory: misaligned write to %h", byte_address);

endmodule

`default_nettype wire

/* hw/predecoder.sv */
`timescale 1ns/1ps
`default_nettype none

// predecode of one fetched word
// control class, target address and static taken prediction
module predecoder (
    input  logic [rv_isa_pkg::INST_W-1:0]  inst,
    input  logic [rv_isa_pkg::ADDR_W-1:0]  inst_pc,
    output fetch_pkg::ctl_class_t          ctl_class,
    output logic [rv_isa_pkg::ADDR_W-1:0]  target,
    output logic                           predict_taken
);

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    // fall-through step
    localparam logic [ADDR_W-1:0] SLOT_STEP = ADDR_W'(INST_BYTES);

    // major opcode of this word
    rv_opcode_t opcode;

    // sign-extended immediates, bit 0 always zero
    logic [ADDR_W-1:0] imm_b;
    logic [ADDR_W-1:0] imm_j;

    // pc-relative targets
    logic [ADDR_W-1:0] branch_target;
    logic [ADDR_W-1:0] jal_target;
    logic [ADDR_W-1:0] seq_target;

    assign opcode = rv_opcode_t'(inst[OPCODE_W-1:0]);

    // b-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign imm_b = {
        {(ADDR_W - 12){inst[31]}},
        inst[7],
        inst[30:25],
        inst[11:8],
        1'b0
    };

    // j-type: imm[20|10:1|11|19:12] in 31:12
    assign imm_j = {
        {(ADDR_W - 20){inst[31]}},
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    assign branch_target = inst_pc + imm_b;
    assign jal_target    = inst_pc + imm_j;
    assign seq_target    = inst_pc + SLOT_STEP;

    always_comb begin
        // default is a plain sequential word
        ctl_class     = ctl_none;
        target        = seq_target;
        predict_taken = 1'b0;
        case (opcode)
            branch: begin
                ctl_class = ctl_branch;
                target    = branch_target;
                // backward taken, forward not taken
                // inst[31] is the sign of the b-type offset
                predict_taken = inst[31];
            end
            jal: begin
                ctl_class     = ctl_jal;
                target        = jal_target;
                predict_taken = 1'b1;
            end
            jalr: begin
                // rs1 not known here, so no target
                // left as the fall-through address and never predicted
                ctl_class = ctl_jalr;
            end
            default: begin
                // alu, memory, upper immediate or unknown, all sequential
                ctl_class = ctl_none;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/fetch_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// pc register, next-pc selection and the registered fetch packet
// one packet per cycle, stall holds, redirect flushes
module fetch_sequencer #(
    parameter logic [rv_isa_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall,
    input  logic                           redirect,
    input  logic [rv_isa_pkg::ADDR_W-1:0]  redirect_pc,
    input  logic [rv_isa_pkg::INST_W-1:0]  curr_inst,
    input  logic [rv_isa_pkg::INST_W-1:0]  next_inst,
    input  logic                           taken0,
    input  logic [rv_isa_pkg::ADDR_W-1:0]  target0,
    input  logic                           taken1,
    input  logic [rv_isa_pkg::ADDR_W-1:0]  target1,
    output logic [rv_isa_pkg::ADDR_W-1:0]  fetch_pc,
    output logic [rv_isa_pkg::ADDR_W-1:0]  slot1_pc,
    output logic                           packet_valid0,
    output logic                           packet_valid1,
    output logic [rv_isa_pkg::ADDR_W-1:0]  packet_pc,
    output logic [rv_isa_pkg::INST_W-1:0]  packet_inst0,
    output logic [rv_isa_pkg::INST_W-1:0]  packet_inst1,
    output logic                           packet_taken0,
    output logic                           packet_taken1
);

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    localparam logic [ADDR_W-1:0] SLOT_STEP   = ADDR_W'(INST_BYTES);
    localparam logic [ADDR_W-1:0] PACKET_STEP = ADDR_W'(PACKET_BYTES);

    // pc of the packet being read from memory now
    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] next_pc;

    // slot 1 is only fetched when slot 0 does not jump away
    logic slot1_ok;

    // advance the pipeline this edge
    logic advance;

    // packet register, control part
    logic valid0_q;
    logic valid1_q;

    // packet register, payload part
    logic [ADDR_W-1:0] pc_pkt_q;
    logic [INST_W-1:0] inst0_q;
    logic [INST_W-1:0] inst1_q;
    logic              taken0_q;
    logic              taken1_q;

    assign fetch_pc = pc_q;
    // slot 1 address, also feeds the second predecoder
    assign slot1_pc = pc_q + SLOT_STEP;

    assign slot1_ok = !taken0;
    assign advance  = !stall && !redirect;

    // next-pc rule
    // slot 0 prediction first, then slot 1, else a full packet step
    always_comb begin
        if (taken0) begin
            next_pc = target0;
        end else if (taken1) begin
            next_pc = target1;
        end else begin
            next_pc = pc_q + PACKET_STEP;
        end
    end

    // pc and valids
    // redirect wins over stall, and clears both valids to flush the packet
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q     <= RESET_PC;
            valid0_q <= 1'b0;
            valid1_q <= 1'b0;
        end else if (redirect) begin
            pc_q     <= redirect_pc;
            valid0_q <= 1'b0;
            valid1_q <= 1'b0;
        end else if (!stall) begin
            pc_q     <= next_pc;
            valid0_q <= 1'b1;
            valid1_q <= slot1_ok;
        end
    end

    // payload captured together with the valids
    // on stall everything holds, so nothing is lost or repeated
    always_ff @(posedge clk) begin
        if (advance) begin
            pc_pkt_q <= pc_q;
            inst0_q  <= curr_inst;
            inst1_q  <= next_inst;
            taken0_q <= taken0;
            taken1_q <= taken1;
        end
    end

    assign packet_valid0 = valid0_q;
    assign packet_valid1 = valid1_q;
    assign packet_pc     = pc_pkt_q;

    // invalid slots show a nop and no prediction
    assign packet_inst0  = valid0_q ? inst0_q : NOP_INST;
    assign packet_inst1  = valid1_q ? inst1_q : NOP_INST;
    assign packet_taken0 = valid0_q && taken0_q;
    assign packet_taken1 = valid1_q && taken1_q;

    // targets and redirects must keep the pc on a word boundary
    pc_aligned_check: assert property (
        @(posedge clk) disable iff (reset) pc_q[1:0] == 2'b00
    ) else $error("fetch_sequencer: pc %h not word aligned", pc_q);

    // slot 1 never valid alone
    slot_order_check: assert property (
        @(posedge clk) disable iff (reset) packet_valid1 |-> packet_valid0
    ) else $error("fetch_sequencer: slot 1 valid without slot 0");

    // a taken slot 0 leaves the packet, slot 1 is past the jump
    taken_cut_check: assert property (
        @(posedge clk) disable iff (reset) !(packet_valid1 && packet_taken0)
    ) else $error("fetch_sequencer: slot 1 valid behind a taken slot 0");

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// fetch front end, top level
// memory, two predecoders and the sequencer
module fetch_unit #(
    parameter int unsigned                   MEM_WORDS = 256,
    parameter logic [rv_isa_pkg::ADDR_W-1:0] RESET_PC  = '0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall,
    input  logic                           redirect,
    input  logic [rv_isa_pkg::ADDR_W-1:0]  redirect_pc,
    input  logic                           load_enable,
    input  logic [rv_isa_pkg::ADDR_W-1:0]  load_address,
    input  logic [rv_isa_pkg::INST_W-1:0]  load_data,
    output logic                           packet_valid0,
    output logic                           packet_valid1,
    output logic [rv_isa_pkg::ADDR_W-1:0]  packet_pc,
    output logic [rv_isa_pkg::INST_W-1:0]  packet_inst0,
    output logic [rv_isa_pkg::INST_W-1:0]  packet_inst1,
    output logic                           packet_taken0,
    output logic                           packet_taken1
);

    import rv_isa_pkg::*;

    // byte address bits that reach into the memory
    localparam int unsigned LOAD_AW = $clog2(MEM_WORDS) + 2;

    // address side
    logic [ADDR_W-1:0] fetch_pc;
    logic [ADDR_W-1:0] slot1_pc;
    logic [ADDR_W-1:0] mem_address;

    // the two words of the packet being read
    logic [INST_W-1:0] curr_inst;
    logic [INST_W-1:0] next_inst;

    // predecode results per slot
    logic [ADDR_W-1:0] target0;
    logic [ADDR_W-1:0] target1;
    logic              taken0;
    logic              taken1;

    // load port borrows the memory address while loading
    assign mem_address = load_enable ? load_address : fetch_pc;

    program_memory #(
        .MEM_WORDS      (MEM_WORDS)
    ) mem_inst (
        .clk            (clk),
        .byte_address   (mem_address),
        .write_enable   (load_enable),
        .write_data     (load_data),
        .curr_read_data (curr_inst),
        .next_read_data (next_inst)
    );

    // slot 0
    predecoder predecode0_inst (
        .inst          (curr_inst),
        .inst_pc       (fetch_pc),
        .ctl_class     (),
        .target        (target0),
        .predict_taken (taken0)
    );

    // slot 1, pc from the sequencer adder
    predecoder predecode1_inst (
        .inst          (next_inst),
        .inst_pc       (slot1_pc),
        .ctl_class     (),
        .target        (target1),
        .predict_taken (taken1)
    );

    fetch_sequencer #(
        .RESET_PC      (RESET_PC)
    ) sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .curr_inst     (curr_inst),
        .next_inst     (next_inst),
        .taken0        (taken0),
        .target0       (target0),
        .taken1        (taken1),
        .target1       (target1),
        .fetch_pc      (fetch_pc),
        .slot1_pc      (slot1_pc),
        .packet_valid0 (packet_valid0),
        .packet_valid1 (packet_valid1),
        .packet_pc     (packet_pc),
        .packet_inst0  (packet_inst0),
        .packet_inst1  (packet_inst1),
        .packet_taken0 (packet_taken0),
        .packet_taken1 (packet_taken1)
    );

    // loads must stay inside the memory, else they alias lower words
    load_range_check: assert property (
        @(posedge clk) load_enable |-> ((load_address >> LOAD_AW) == '0)
    ) else $error("fetch_unit: load address %h beyond memory", load_address);

endmodule

`default_nettype wire

/* testbench/tb_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the fetch front end
// a small looping program under random stall and redirect
module tb_fetch_unit;

    localparam int MEM_WORDS = 256;
    localparam int WORD_AW = $clog2(MEM_WORDS);
    localparam logic [31:0] RESET_PC = 32'h0;
    // redirect targets stay inside the program words
    localparam int PROG_WORDS = 24;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES = 800;
    // load, reset, quiet start, random traffic and drain
    localparam int TOTAL_CYCLES = MEM_WORDS + RESET_CYCLES + NUM_CYCLES + 16;
    localparam int WATCHDOG_NS = TOTAL_CYCLES * 40 * 2;
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // one expected packet, plus where fetch goes after it
    typedef struct packed {
        logic        valid0;
        logic        valid1;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic        taken0;
        logic        taken1;
        logic [31:0] next_pc;
    } packet_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        load_enable;
    logic [31:0] load_address;
    logic [31:0] load_data;
    logic        packet_valid0;
    logic        packet_valid1;
    logic [31:0] packet_pc;
    logic [31:0] packet_inst0;
    logic [31:0] packet_inst1;
    logic        packet_taken0;
    logic        packet_taken1;

    // mirror of what was written into the program memory
    logic [31:0] image [MEM_WORDS];
    integer seed;
    int checks = 0;
    int mismatches = 0;
    int other_errors = 0;
    int valid_packets = 0;
    int taken0_packets = 0;
    int taken1_packets = 0;

    // rv32i encoders for the test program
    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // test program, loops back to 0 through a jal in slot 1
    function automatic logic [31:0] program_word(input int idx);
        case (idx)
            0: return enc_i(OPC_IMM, 5'd1, 5'd0, 12'd1);
            1: return enc_i(OPC_IMM, 5'd2, 5'd0, 12'd2);
            2: return enc_add(5'd3, 5'd1, 5'd2);
            3: return enc_add(5'd4, 5'd3, 5'd1);
            // forward bne in slot 0, falls through
            4: return enc_b(3'b001, 5'd1, 5'd2, 13'd16);
            5: return enc_i(OPC_IMM, 5'd5, 5'd0, 12'd5);
            // jalr in slot 0, never predicted
            6: return enc_i(OPC_JALR, 5'd0, 5'd1, 12'd0);
            7: return enc_i(OPC_IMM, 5'd6, 5'd0, 12'd6);
            8: return enc_i(OPC_IMM, 5'd7, 5'd0, 12'd7);
            // jal in slot 1, 36 to 52
            9: return enc_j(5'd0, 21'd16);
            10: return enc_i(OPC_IMM, 5'd8, 5'd0, 12'd10);
            // jal in slot 1, 44 to 60, skips the loop branch
            11: return enc_j(5'd0, 21'd16);
            12: return enc_i(OPC_IMM, 5'd9, 5'd0, 12'd12);
            // backward beq in slot 0, 52 to 40
            13: return enc_b(3'b000, 5'd1, 5'd1, -13'd12);
            14: return enc_add(5'd10, 5'd1, 5'd2);
            15: return enc_i(OPC_IMM, 5'd11, 5'd0, 12'd15);
            16: return enc_add(5'd12, 5'd11, 5'd1);
            17: return enc_i(OPC_IMM, 5'd13, 5'd0, 12'd17);
            18: return enc_add(5'd14, 5'd13, 5'd12);
            19: return enc_i(OPC_IMM, 5'd15, 5'd0, 12'd19);
            // negative jal in slot 1, 80 back to 0
            20: return enc_j(5'd1, -21'd80);
            // filler carries its own word index
            default: return enc_i(OPC_IMM, 5'd31, 5'd0, 12'(idx));
        endcase
    endfunction

    // static rule: jal always, branch only when backward
    function automatic logic predicted(input logic [31:0] w);
        case (w[6:0])
            7'b1101111: return 1'b1;
            7'b1100011: return w[31];
            default: return 1'b0;
        endcase
    endfunction

    // j-type offset for jal, b-type offset otherwise
    function automatic logic [31:0] offset_of(input logic [31:0] w);
        if (w[6:0] == 7'b1101111) begin
            return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    // flushed or reset packet
    function automatic packet_t empty_packet();
        packet_t pkt;
        pkt = '0;
        pkt.inst0 = NOP_WORD;
        pkt.inst1 = NOP_WORD;
        return pkt;
    endfunction

    // reference model of one packet read at pc
    function automatic packet_t expected_packet(input logic [31:0] pc,
                                                input logic [31:0] image_in [MEM_WORDS]);
        packet_t pkt;
        logic [31:0] pc1;
        pc1 = pc + 32'd4;
        // word index wraps with the memory depth
        pkt.inst0 = image_in[pc[WORD_AW+1:2]];
        pkt.inst1 = image_in[pc1[WORD_AW+1:2]];
        pkt.valid0 = 1'b1;
        pkt.taken0 = predicted(pkt.inst0);
        // slot 1 lies past a taken slot 0
        pkt.valid1 = !pkt.taken0;
        pkt.taken1 = pkt.valid1 && predicted(pkt.inst1);
        if (pkt.taken0) begin
            pkt.next_pc = pc + offset_of(pkt.inst0);
        end else if (pkt.taken1) begin
            pkt.next_pc = pc1 + offset_of(pkt.inst1);
        end else begin
            pkt.next_pc = pc + 32'd8;
        end
        if (!pkt.valid1) begin
            pkt.inst1 = NOP_WORD;
        end
        return pkt;
    endfunction

    task automatic check_field(input string field, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, field, got, expected);
            mismatches++;
        end
    endtask

    fetch_unit #(
        .MEM_WORDS     (MEM_WORDS),
        .RESET_PC      (RESET_PC)
    ) fetch_unit_inst (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .load_enable   (load_enable),
        .load_address  (load_address),
        .load_data     (load_data),
        .packet_valid0 (packet_valid0),
        .packet_valid1 (packet_valid1),
        .packet_pc     (packet_pc),
        .packet_inst0  (packet_inst0),
        .packet_inst1  (packet_inst1),
        .packet_taken0 (packet_taken0),
        .packet_taken1 (packet_taken1)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // load under reset, then random stall and redirect traffic
    initial begin
        seed = 32'h7007;
        reset = 1'b1;
        stall = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        load_enable = 1'b0;
        load_address = '0;
        load_data = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = program_word(i);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            load_enable <= 1'b1;
            load_address <= 32'(i * 4);
            load_data <= image[i];
        end
        @(posedge clk);
        load_enable <= 1'b0;
        // reset stays high for three more cycles after the load
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // quiet start so the first packet comes from the reset pc
        repeat (4) @(posedge clk);
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(posedge clk);
            redirect_pc <= ($unsigned($random(seed)) % PROG_WORDS) * 4;
            if (cycle % 100 == 60) begin
                // redirect together with stall
                stall <= 1'b1;
                redirect <= 1'b1;
            end else begin
                stall <= ($unsigned($random(seed)) % 100) < 20;
                // single-cycle pulses only
                redirect <= !redirect && (($unsigned($random(seed)) % 100) < 5);
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        redirect <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        #1;
        assert (valid_packets > 0 && taken0_packets > 0 && taken1_packets > 0) else begin
            $display("the run never saw predicted jumps in both slots");
            other_errors++;
        end
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // model follows the same edges as the DUT, compares at the falling edge
    initial begin : compare_outputs
        packet_t expected;
        logic [31:0] model_pc;
        logic [31:0] expected_pc;
        logic first_seen;
        model_pc = RESET_PC;
        expected_pc = RESET_PC;
        expected = empty_packet();
        first_seen = 1'b0;
        forever begin
            // stimulus updates land after this point, so these are the sampled values
            @(posedge clk);
            if (reset || redirect) begin
                // redirect wins over stall and flushes the packet
                model_pc = reset ? RESET_PC : redirect_pc;
                expected = empty_packet();
            end else if (!stall) begin
                expected = expected_packet(model_pc, image);
                expected_pc = model_pc;
                model_pc = expected.next_pc;
            end
            @(negedge clk);
            check_field("packet_valid0", 32'(packet_valid0), 32'(expected.valid0));
            check_field("packet_valid1", 32'(packet_valid1), 32'(expected.valid1));
            check_field("packet_inst0", packet_inst0, expected.inst0);
            check_field("packet_inst1", packet_inst1, expected.inst1);
            check_field("packet_taken0", 32'(packet_taken0), 32'(expected.taken0));
            check_field("packet_taken1", 32'(packet_taken1), 32'(expected.taken1));
            // pc only means something in a valid packet
            if (expected.valid0) begin
                check_field("packet_pc", packet_pc, expected_pc);
                valid_packets++;
                taken0_packets += int'(expected.taken0);
                taken1_packets += int'(expected.taken1);
            end
            if (packet_valid0 && !first_seen) begin
                first_seen = 1'b1;
                check_field("first packet_pc", packet_pc, RESET_PC);
            end
        end
    end

    // ends a hung run
    initial begin
        #WATCHDOG_NS;
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_unit.f */
hw/rv_isa_pkg.sv
hw/fetch_pkg.sv
hw/program_memory.sv
hw/predecoder.sv
hw/fetch_sequencer.sv
hw/fetch_unit.sv
testbench/tb_fetch_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the fetch unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f fetch_unit.f \
    --top-module tb_fetch_unit \
    -o sim_fetch_unit

./obj_dir/sim_fetch_unit 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
